// ==== design/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // ----------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------

    localparam int WORD_IDX_W = 10;          // Word index into the data RAM

    typedef logic [31:0] data_t;             // Data word
    typedef logic [31:0] inst_addr_t;        // Instruction address (PC)
    typedef logic [3:0]  byte_en_t;          // One enable per byte lane

    // Access size of a load or store
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_t;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_RESULT = 2'b00,                   // Execute result
        WB_MEM    = 2'b01,                   // Loaded data
        WB_PC4    = 2'b10                    // Return address
    } wb_sel_t;

    // ----------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------

    typedef struct packed {
        logic                  en;           // Access this cycle
        logic                  we;           // Write, else read
        byte_en_t              byte_en;      // Lanes written
        logic [WORD_IDX_W-1:0] word_idx;     // Word address
        data_t                 wdata;        // Lane-placed store data
    } mem_req_t;

    typedef struct packed {
        logic    wr_en;                      // Store
        logic    rd_en;                      // Load
        access_t access;                     // Byte, half or word
        logic    is_unsigned;                // Zero-extend on load
    } lsu_ctrl_t;

endpackage

// ==== design/mem_access_fsm.sv ====
`timescale 1ns/1ps

module mem_access_fsm #(
    parameter int MEM_LATENCY = 2                       // Stall length of at least 1
) (
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_is_valid,        // Instruction present
    input  mem_stage_pkg::lsu_ctrl_t i_lsu,             // Memory controls
    input  logic                     i_misaligned,      // From the aligner
    input  logic [1:0]               i_byte_off,        // Low address bits
    input  mem_stage_pkg::mem_req_t  i_req,             // Raw request
    input  logic                     i_timer_expired,   // Last wait cycle
    output logic                     o_timer_start,
    output mem_stage_pkg::mem_req_t  o_ram_req,         // Gated request
    output logic                     o_hazard,          // Stall upstream
    output logic                     o_align_error,     // One-cycle pulse
    output logic                     o_load_done,       // High in DONE
    output logic [1:0]               o_byte_off         // Offset held for DONE
);

    localparam bit DIRECT = (MEM_LATENCY == 1);         // No wait state needed

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   is_access;                                  // Valid load or store
    logic   start;                                      // Aligned access begins
    logic   fire;                                       // RAM access this cycle

    assign is_access = i_is_valid && (i_lsu.rd_en || i_lsu.wr_en);
    assign start     = (state == IDLE) && is_access && !i_misaligned;
    assign fire      = (start && DIRECT) || ((state == WAIT) && i_timer_expired);

    // ----------------------------------------------------------
    // State sequencing
    // ----------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (start) state_nxt = DIRECT ? DONE : WAIT;
            WAIT: if (i_timer_expired) state_nxt = DONE;
            DONE: state_nxt = IDLE;                     // Always one cycle
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= IDLE;
            o_byte_off <= '0;
        end else begin
            state <= state_nxt;
            if (start) o_byte_off <= i_byte_off;        // Offset captured when the access starts
        end
    end

    // Request passes with en and we only on the firing cycle
    always_comb begin
        o_ram_req    = i_req;
        o_ram_req.en = i_req.en && fire;
        o_ram_req.we = i_req.we && fire;
    end

    assign o_timer_start = start;
    assign o_hazard      = start || (state == WAIT);
    assign o_align_error = (state == IDLE) && is_access && i_misaligned;
    assign o_load_done   = (state == DONE);

endmodule

// ==== design/mem_latency_timer.sv ====
`timescale 1ns/1ps

module mem_latency_timer #(
    parameter int MEM_LATENCY = 2                   // Access latency, at least 1
) (
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_start,                           // Access begins
    output logic o_expired                          // Last wait cycle
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(MEM_LATENCY - 1);   // Wait cycles

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (i_start) begin
            count <= LOAD_VAL;                      // Reload on every start
        end else if (count != '0) begin
            count <= count - 1'b1;                  // Stops at zero
        end
    end

    // Single-cycle latency has no wait state at all
    assign o_expired = (MEM_LATENCY == 1) || (count == CNT_W'(1));

endmodule

// ==== design/store_aligner.sv ====
`timescale 1ns/1ps

module store_aligner (
    input  mem_stage_pkg::data_t     i_addr,        // Byte address
    input  mem_stage_pkg::data_t     i_wr_data,     // Store data, low-aligned
    input  mem_stage_pkg::lsu_ctrl_t i_lsu,
    output mem_stage_pkg::mem_req_t  o_req,         // Raw request, not gated
    output logic                     o_misaligned
);
    import mem_stage_pkg::*;

    logic [1:0] off;                                // Byte within word
    byte_en_t   byte_en;
    data_t      wdata;
    logic       is_mem;

    assign off    = i_addr[1:0];
    assign is_mem = i_lsu.rd_en || i_lsu.wr_en;

    // ----------------------------------------------------------
    // Lane placement
    // ----------------------------------------------------------

    always_comb begin
        case (i_lsu.access)
            ACC_BYTE: begin
                byte_en = byte_en_t'(4'b0001 << off);
                wdata   = {4{i_wr_data[7:0]}};      // Byte in every lane
            end
            ACC_HALF: begin
                byte_en = off[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{i_wr_data[15:0]}};     // Half in both halves
            end
            default: begin                          // Word
                byte_en = 4'b1111;
                wdata   = i_wr_data;
            end
        endcase
    end

    // Half needs even address, word needs a multiple of 4
    always_comb begin
        case (i_lsu.access)
            ACC_HALF: o_misaligned = is_mem && off[0];
            ACC_WORD: o_misaligned = is_mem && (off != 2'b00);
            default:  o_misaligned = 1'b0;
        endcase
    end

    assign o_req.en       = is_mem;
    assign o_req.we       = i_lsu.wr_en;
    assign o_req.byte_en  = byte_en;
    assign o_req.word_idx = i_addr[WORD_IDX_W+1:2];
    assign o_req.wdata    = wdata;

endmodule

// ==== design/load_writeback.sv ====
`timescale 1ns/1ps

module load_writeback (
    input  mem_stage_pkg::data_t      i_rd_word,      // Registered RAM word
    input  logic [1:0]                i_byte_off,     // Byte within word
    input  mem_stage_pkg::lsu_ctrl_t  i_lsu,
    input  logic                      i_rd_ok,        // RAM word is valid
    input  mem_stage_pkg::inst_addr_t i_pc,
    input  mem_stage_pkg::data_t      i_result,       // Execute result
    input  mem_stage_pkg::wb_sel_t    i_wb_sel,
    output mem_stage_pkg::data_t      o_reg_wr_data
);
    import mem_stage_pkg::*;

    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    data_t       rd_ext;                              // Extended load value
    data_t       mem_data;
    inst_addr_t  pc_plus4;

    // ----------------------------------------------------------
    // Lane extraction and extension
    // ----------------------------------------------------------

    assign rd_byte = i_rd_word[8*i_byte_off +: 8];
    assign rd_half = i_byte_off[1] ? i_rd_word[31:16] : i_rd_word[15:0];

    always_comb begin
        case (i_lsu.access)
            ACC_BYTE: begin
                if (i_lsu.is_unsigned) rd_ext = {24'b0, rd_byte};
                else                   rd_ext = {{24{rd_byte[7]}}, rd_byte};
            end
            ACC_HALF: begin
                if (i_lsu.is_unsigned) rd_ext = {16'b0, rd_half};
                else                   rd_ext = {{16{rd_half[15]}}, rd_half};
            end
            default: rd_ext = i_rd_word;              // Word needs no extension
        endcase
    end

    // Zero unless a load has just completed
    assign mem_data = i_rd_ok ? rd_ext : '0;

    assign pc_plus4 = i_pc + inst_addr_t'(4);         // Return address

    // ----------------------------------------------------------
    // Write-back select
    // ----------------------------------------------------------

    always_comb begin
        case (i_wb_sel)
            WB_MEM:  o_reg_wr_data = mem_data;
            WB_PC4:  o_reg_wr_data = pc_plus4;
            default: o_reg_wr_data = i_result;        // WB_RESULT
        endcase
    end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 1024                  // Depth in words
) (
    input  logic                    i_clock,
    input  mem_stage_pkg::mem_req_t i_req,          // Gated request
    output mem_stage_pkg::data_t    o_rd_data       // Read word, one cycle later
);
    import mem_stage_pkg::*;

    data_t mem [RAM_WORDS];

    // Byte-lane writes
    always_ff @(posedge i_clock) begin
        if (i_req.en && i_req.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (i_req.byte_en[lane]) begin
                    mem[i_req.word_idx][8*lane +: 8] <= i_req.wdata[8*lane +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-cycle write
    always_ff @(posedge i_clock) begin
        if (i_req.en) begin
            o_rd_data <= mem[i_req.word_idx];   // Held until the next access
        end
    end

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int MEM_LATENCY = 2,                              // Stall cycles per access
    parameter int RAM_WORDS   = 2 ** mem_stage_pkg::WORD_IDX_W  // Data RAM depth
) (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  logic                      i_is_valid,       // Instruction present
    input  mem_stage_pkg::inst_addr_t i_pc,
    input  mem_stage_pkg::data_t      i_data_r,         // Result and byte address
    input  mem_stage_pkg::data_t      i_data_b,         // Store data
    input  mem_stage_pkg::lsu_ctrl_t  i_lsu,
    input  mem_stage_pkg::wb_sel_t    i_wb_sel,
    output logic                      o_hazard,         // Stall upstream
    output logic                      o_align_error,
    output mem_stage_pkg::data_t      o_reg_wr_data
);
    import mem_stage_pkg::*;

    mem_req_t   aligner_req;                            // Raw request
    mem_req_t   ram_req;                                // Gated by the FSM
    logic       misaligned;
    logic       timer_start;
    logic       timer_expired;
    data_t      rd_word;
    logic       load_done;
    logic [1:0] byte_off;                               // Held offset for DONE

    // ----------------------------------------------------------
    // Access control
    // ----------------------------------------------------------

    mem_access_fsm #(.MEM_LATENCY(MEM_LATENCY)) u_fsm (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_is_valid      (i_is_valid),
        .i_lsu           (i_lsu),
        .i_misaligned    (misaligned),
        .i_byte_off      (i_data_r[1:0]),
        .i_req           (aligner_req),
        .i_timer_expired (timer_expired),
        .o_timer_start   (timer_start),
        .o_ram_req       (ram_req),
        .o_hazard        (o_hazard),
        .o_align_error   (o_align_error),
        .o_load_done     (load_done),
        .o_byte_off      (byte_off)
    );

    mem_latency_timer #(.MEM_LATENCY(MEM_LATENCY)) u_timer (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_start   (timer_start),
        .o_expired (timer_expired)
    );

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------

    store_aligner u_aligner (
        .i_addr       (i_data_r),
        .i_wr_data    (i_data_b),
        .i_lsu        (i_lsu),
        .o_req        (aligner_req),
        .o_misaligned (misaligned)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .i_clock   (i_clock),
        .i_req     (ram_req),
        .o_rd_data (rd_word)
    );

    load_writeback u_wb (
        .i_rd_word     (rd_word),
        .i_byte_off    (byte_off),
        .i_lsu         (i_lsu),
        .i_rd_ok       (load_done),                     // Load data valid in DONE
        .i_pc          (i_pc),
        .i_result      (i_data_r),
        .i_wb_sel      (i_wb_sel),
        .o_reg_wr_data (o_reg_wr_data)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,                // Clock period
    parameter int RESET_CYCLES = 2                  // Cycles with reset held low
) (
    output logic o_clock,
    output logic o_rst_n
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

    // Reset released on a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_rst_n <= 1'b1;
    end

endmodule

// ==== bench/mem_stage_assert.sv ====
`timescale 1ns/1ps

module mem_stage_assert #(
    parameter int MEM_LATENCY = 2                   // Expected stall length
) (
    input logic i_clock,
    input logic i_rst_n,
    input logic i_hazard,
    input logic i_align_error
);

    logic [7:0] run_len;                            // Consecutive stall cycles so far

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_len <= '0;
        end else if (i_hazard) begin
            run_len <= run_len + 8'd1;
        end else begin
            run_len <= '0;
        end
    end

    // ----------------------------------------------------------
    // Properties
    // ----------------------------------------------------------

    a_excl: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_hazard && i_align_error))
        else $error("o_hazard and o_align_error high in the same cycle");

    // Stall no longer than MEM_LATENCY
    a_len_max: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_hazard |-> (run_len < 8'(MEM_LATENCY)))
        else $error("o_hazard held longer than MEM_LATENCY cycles");

    // And no shorter
    a_len_min: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $fell(i_hazard) |-> (run_len == 8'(MEM_LATENCY)))
        else $error("o_hazard dropped before MEM_LATENCY cycles");

    a_rst: assert property (@(posedge i_clock) !i_rst_n |-> !i_align_error)
        else $error("o_align_error high during reset");

endmodule

bind mem_stage mem_stage_assert #(.MEM_LATENCY(MEM_LATENCY)) u_assert (
    .i_clock       (i_clock),
    .i_rst_n       (i_rst_n),
    .i_hazard      (o_hazard),
    .i_align_error (o_align_error)
);

// ==== bench/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int MEM_LATENCY    = 2;
    localparam int TIMEOUT_CYCLES = 20;             // Limit for every wait

    typedef struct packed {
        data_t      data;                           // Expected write-back value
        logic       align_err;
        logic [7:0] haz_cycles;                     // Expected stall length
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       i_is_valid;
    inst_addr_t i_pc;
    data_t      i_data_r;
    data_t      i_data_b;
    lsu_ctrl_t  i_lsu;
    wb_sel_t    i_wb_sel;
    logic       o_hazard;
    logic       o_align_error;
    data_t      o_reg_wr_data;

    logic [7:0]  shadow [4096];                     // Byte image of the data RAM
    logic [31:0] lfsr      = 32'hff7f0704;
    expect_t     exp_q[$];                          // One entry per instruction
    logic [7:0]  haz_cnt   = '0;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;
    logic        timed_out = 1'b0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk (.o_clock(clk), .o_rst_n(rst_n));

    mem_stage #(.MEM_LATENCY(MEM_LATENCY)) u_dut (
        .i_clock       (clk),
        .i_rst_n       (rst_n),
        .i_is_valid    (i_is_valid),
        .i_pc          (i_pc),
        .i_data_r      (i_data_r),
        .i_data_b      (i_data_b),
        .i_lsu         (i_lsu),
        .i_wb_sel      (i_wb_sel),
        .o_hazard      (o_hazard),
        .o_align_error (o_align_error),
        .o_reg_wr_data (o_reg_wr_data)
    );

    // ----------------------------------------------------------
    // Random source and reference model
    // ----------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic data_t rand_bits(int n);
        data_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic lsu_ctrl_t make_lsu(logic wr, logic rd, access_t acc, logic uns);
        lsu_ctrl_t l;
        l.wr_en       = wr;
        l.rd_en       = rd;
        l.access      = acc;
        l.is_unsigned = uns;
        return l;
    endfunction

    // Half needs an even address, word a multiple of 4
    function automatic logic is_misaligned(lsu_ctrl_t lsu, data_t addr);
        if (!(lsu.rd_en || lsu.wr_en)) return 1'b0;
        case (lsu.access)
            ACC_HALF: return addr[0];
            ACC_WORD: return addr[1:0] != 2'b00;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic data_t expected_wb(lsu_ctrl_t lsu, wb_sel_t sel, data_t addr,
                                          inst_addr_t pc);
        logic [11:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        data_t       loaded;
        a      = addr[11:0];
        loaded = '0;                                // Zero unless an aligned load
        if (lsu.rd_en && !is_misaligned(lsu, addr)) begin
            case (lsu.access)
                ACC_BYTE: begin
                    b      = shadow[a];
                    loaded = lsu.is_unsigned ? {24'h0, b} : {{24{b[7]}}, b};
                end
                ACC_HALF: begin
                    h      = {shadow[a + 12'd1], shadow[a]};   // Little endian
                    loaded = lsu.is_unsigned ? {16'h0, h} : {{16{h[15]}}, h};
                end
                default: loaded = {shadow[a + 12'd3], shadow[a + 12'd2],
                                   shadow[a + 12'd1], shadow[a]};
            endcase
        end
        case (sel)
            WB_MEM:  return loaded;
            WB_PC4:  return pc + 32'd4;
            default: return addr;                   // Execute result
        endcase
    endfunction

    function automatic void update_shadow(lsu_ctrl_t lsu, data_t addr, data_t wdata);
        logic [11:0] a;
        a = addr[11:0];
        if (lsu.wr_en && !is_misaligned(lsu, addr)) begin
            shadow[a] = wdata[7:0];
            if (lsu.access != ACC_BYTE) shadow[a + 12'd1] = wdata[15:8];
            if (lsu.access == ACC_WORD) begin
                shadow[a + 12'd2] = wdata[23:16];
                shadow[a + 12'd3] = wdata[31:24];
            end
        end
    endfunction

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    task automatic report_mismatch(input string name, input data_t expv, input data_t actv);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, expv, actv);
        fail_cnt++;
    endtask

    task automatic exec_instr(input lsu_ctrl_t lsu, input wb_sel_t sel, input data_t addr,
                              input data_t wdata, input inst_addr_t pc);
        expect_t expd;
        logic    mis;
        logic    is_mem;
        logic    fell;
        int      cyc;
        if (!timed_out) begin
            mis             = is_misaligned(lsu, addr);
            is_mem          = lsu.rd_en || lsu.wr_en;
            expd.data       = expected_wb(lsu, sel, addr, pc);
            expd.align_err  = is_mem && mis;
            expd.haz_cycles = (is_mem && !mis) ? 8'(MEM_LATENCY) : 8'd0;
            exp_q.push_back(expd);
            update_shadow(lsu, addr, wdata);
            @(posedge clk);
            i_is_valid <= 1'b1;
            i_pc       <= pc;
            i_data_r   <= addr;
            i_data_b   <= wdata;
            i_lsu      <= lsu;
            i_wb_sel   <= sel;
            fell = 1'b0;
            cyc  = 0;
            while (!fell && cyc < TIMEOUT_CYCLES) begin
                @(negedge clk);
                if (!o_hazard) fell = 1'b1;         // Upstream may advance
                cyc++;
            end
            if (!fell) begin
                timed_out = 1'b1;
                $display("Timeout at %0t: o_hazard stayed high for %0d cycles",
                         $time, TIMEOUT_CYCLES);
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int fails_before);
        @(posedge clk);
        i_is_valid <= 1'b0;
        i_lsu      <= '0;
        $display("Test %0d %s: %0d errors", num, name, fail_cnt - fails_before);
    endtask

    // Compare on the falling edge, where outputs are settled
    always @(negedge clk) begin
        expect_t cur;
        if (rst_n && i_is_valid) begin
            if (o_hazard) begin
                haz_cnt = haz_cnt + 8'd1;
            end else begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: instruction completed with nothing expected", $time);
                    fail_cnt++;
                end else begin
                    cur = exp_q.pop_front();
                    if (o_reg_wr_data !== cur.data)
                        report_mismatch("o_reg_wr_data", cur.data, o_reg_wr_data);
                    else
                        pass_cnt++;
                    if (o_align_error !== cur.align_err)
                        report_mismatch("o_align_error", {31'd0, cur.align_err},
                                        {31'd0, o_align_error});
                    else
                        pass_cnt++;
                    if (haz_cnt !== cur.haz_cycles)
                        report_mismatch("o_hazard cycles", {24'd0, cur.haz_cycles},
                                        {24'd0, haz_cnt});
                    else
                        pass_cnt++;
                end
                haz_cnt = '0;
            end
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        data_t   base;
        wb_sel_t sel;
        int      fails;
        int      cyc;
        i_is_valid = 1'b0;
        i_pc       = '0;
        i_data_r   = '0;
        i_data_b   = '0;
        i_lsu      = '0;
        i_wb_sel   = WB_RESULT;

        // Reset state
        fails = fail_cnt;
        cyc   = 0;
        while (rst_n !== 1'b1 && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: reset was never released", $time);
        end
        @(negedge clk);
        if (o_hazard !== 1'b0) report_mismatch("o_hazard", '0, {31'd0, o_hazard});
        else pass_cnt++;
        if (o_align_error !== 1'b0) report_mismatch("o_align_error", '0, {31'd0, o_align_error});
        else pass_cnt++;
        finish_test(1, "reset state", fails);

        fails = fail_cnt;
        for (int n = 0; n < 8; n++) begin
            base = rand_bits(32) & 32'hffff_fffc;
            exec_instr(make_lsu(1'b1, 1'b0, ACC_WORD, 1'b0), WB_RESULT, base, rand_bits(32),
                       rand_bits(32));
            exec_instr(make_lsu(1'b0, 1'b1, ACC_WORD, 1'b0), WB_MEM, base, '0, rand_bits(32));
        end
        finish_test(2, "word store and load", fails);

        // Full word first so every byte read is defined
        fails = fail_cnt;
        for (int n = 0; n < 4; n++) begin
            base = rand_bits(32) & 32'hffff_fffc;
            exec_instr(make_lsu(1'b1, 1'b0, ACC_WORD, 1'b0), WB_RESULT, base, rand_bits(32),
                       rand_bits(32));
            exec_instr(make_lsu(1'b1, 1'b0, ACC_BYTE, 1'b0), WB_RESULT, base + rand_bits(2),
                       rand_bits(32), rand_bits(32));
            exec_instr(make_lsu(1'b1, 1'b0, ACC_HALF, 1'b0), WB_RESULT,
                       base + (rand_bits(1) << 1), rand_bits(32), rand_bits(32));
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    exec_instr(make_lsu(1'b0, 1'b1, ACC_BYTE, u[0]), WB_MEM, base + 32'(off),
                               '0, rand_bits(32));
                    if (off[0] == 1'b0)
                        exec_instr(make_lsu(1'b0, 1'b1, ACC_HALF, u[0]), WB_MEM,
                                   base + 32'(off), '0, rand_bits(32));
                end
            end
            exec_instr(make_lsu(1'b0, 1'b1, ACC_WORD, 1'b0), WB_MEM, base, '0, rand_bits(32));
        end
        finish_test(3, "byte and half access", fails);

        // Refused accesses leave the word intact
        fails = fail_cnt;
        for (int n = 0; n < 3; n++) begin
            base = rand_bits(32) & 32'hffff_fffc;
            exec_instr(make_lsu(1'b1, 1'b0, ACC_WORD, 1'b0), WB_RESULT, base, rand_bits(32),
                       rand_bits(32));
            for (int off = 1; off < 4; off++) begin
                exec_instr(make_lsu(1'b1, 1'b0, ACC_WORD, 1'b0), WB_RESULT, base + 32'(off),
                           rand_bits(32), rand_bits(32));
                if (off[0])
                    exec_instr(make_lsu(1'b1, 1'b0, ACC_HALF, 1'b0), WB_RESULT,
                               base + 32'(off), rand_bits(32), rand_bits(32));
                exec_instr(make_lsu(1'b0, 1'b1, ACC_WORD, 1'b0), WB_MEM, base + 32'(off),
                           '0, rand_bits(32));
            end
            exec_instr(make_lsu(1'b0, 1'b1, ACC_WORD, 1'b0), WB_MEM, base, '0, rand_bits(32));
        end
        finish_test(4, "misaligned access", fails);

        fails = fail_cnt;
        for (int n = 0; n < 8; n++) begin
            if (n[0]) sel = WB_PC4;
            else      sel = WB_RESULT;
            exec_instr(make_lsu(1'b0, 1'b0, ACC_WORD, 1'b0), sel, rand_bits(32), rand_bits(32),
                       rand_bits(32));
        end
        finish_test(5, "non-memory instructions", fails);

        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (timed_out || fail_cnt != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/mem_stage_pkg.sv
design/mem_access_fsm.sv
design/mem_latency_timer.sv
design/store_aligner.sv
design/load_writeback.sv
design/data_ram.sv
design/mem_stage.sv
bench/tb_clock_gen.sv
bench/mem_stage_assert.sv
bench/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mem_stage testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_mem_stage -Mdir "$BUILD_DIR" -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_mem_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
